/* design/fetch_params.svh */
/* widths and depth of the uncached fetch path
   FETCH_DEPTH must be a power of two, 2 or more; FETCH_TAG_W is log2 of FETCH_NPARCEL */
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// datapath
`define FETCH_XLEN     32   // data and address width
`define FETCH_PARCEL   16   // parcel width
`define FETCH_NPARCEL  2    // parcels per bus word
`define FETCH_TAG_W    1    // halfword offset carried as bus tag

// queueing
`define FETCH_DEPTH    2    // outstanding bus reads, 2 or 4

// features
`define FETCH_HAS_RVC  1    // 1 lets a fetch start on a halfword
`define FETCH_CNT_W    16   // status counter width

`endif

/* design/fetch_pkg.sv */
/* shared types of the fetch subsystem
   field order inside each struct is fixed; the bench relies on it */
`include "fetch_params.svh"

package fetch_pkg;

  //////////////////////////////
  // bus attributes
  //////////////////////////////
  typedef struct packed {
    logic instr;      // always an instruction fetch here
    logic priv;       // privileged access
    logic cacheable;  // region may be cached
  } fetch_prot_t;

  // request from core into the bus interface unit
  typedef struct packed {
    logic [`FETCH_XLEN-1:0]  addr;  // word aligned
    logic [`FETCH_TAG_W-1:0] tag;   // halfword offset of the fetch start
    fetch_prot_t             prot;
  } biu_req_t;

  // reply, one cycle per word
  typedef struct packed {
    logic [`FETCH_XLEN-1:0]  data;
    logic [`FETCH_XLEN-1:0]  addr;  // echoed request address
    logic [`FETCH_TAG_W-1:0] tag;   // echoed tag
    logic                    ack;
    logic                    err;
  } biu_rsp_t;

  // parcel word handed back to the cpu
  typedef struct packed {
    logic [`FETCH_XLEN-1:0]    pc;
    logic [`FETCH_XLEN-1:0]    data;
    logic [`FETCH_NPARCEL-1:0] valid;  // one bit per halfword
    logic                      err;
  } parcel_t;

  // steering from the config block
  typedef struct packed {
    logic        fetch_en;
    fetch_prot_t prot;
  } fetch_cfg_t;

  //////////////////////////////
  // encodings
  //////////////////////////////
  typedef enum logic {
    CFG_READ  = 1'b0,
    CFG_WRITE = 1'b1
  } cfg_op_e;

  typedef enum logic [1:0] {
    REG_CTRL    = 2'd0,  // bit 0 fetch enable
    REG_PROT    = 2'd1,  // bits 2:0 prot
    REG_PARCELS = 2'd2,  // delivered parcel words, read only
    REG_ERRORS  = 2'd3   // bus error parcels, read only
  } cfg_reg_e;

  typedef enum logic [1:0] {
    MEM_IDLE    = 2'd0,
    MEM_REQ     = 2'd1,
    MEM_RELEASE = 2'd2
  } mem_state_e;

endpackage

/* design/fetch_nocache_core.sv */
/* cpu side of the uncached fetch, no registers in the data path
   with FETCH_HAS_RVC at 0 a halfword pc is fetched as its aligned word */
`include "fetch_params.svh"

module fetch_nocache_core (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // cpu side
  input  logic [`FETCH_XLEN-1:0]     if_nxt_pc_i,
  input  logic                       if_req_i,
  output logic                       if_ack_o,
  input  logic                       if_flush_i,
  output fetch_pkg::parcel_t         parcel_o,
  // config block
  input  fetch_pkg::fetch_cfg_t      cfg_i,
  // bus interface unit
  output logic                       biu_stb_o,
  input  logic                       biu_stb_ack_i,
  output fetch_pkg::biu_req_t        biu_req_o,
  input  fetch_pkg::biu_rsp_t        biu_rsp_i
);

  // enough to hold FETCH_DEPTH outstanding reads
  localparam int unsigned CNT_W = $clog2(`FETCH_DEPTH) + 1;

  //////////////////////////////
  // signals
  //////////////////////////////
  logic             flush_dly_q;  // flush seen last cycle
  logic [CNT_W-1:0] inflight_q;   // strobes accepted, reply not yet seen
  logic [CNT_W-1:0] discard_q;    // stale replies still to drop
  logic             stb_acc;      // strobe taken by the biu this cycle
  logic             rsp_hit;      // a reply arrives this cycle
  logic             rsp_show;     // reply may reach the cpu

  assign stb_acc = biu_stb_o & biu_stb_ack_i;
  assign rsp_hit = biu_rsp_i.ack | biu_rsp_i.err;

  //////////////////////////////
  // flush bookkeeping
  //////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      flush_dly_q <= 1'b0;
    else
      flush_dly_q <= if_flush_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      inflight_q <= '0;
    else
    begin
      case ({stb_acc, rsp_hit})
        2'b10:   inflight_q <= inflight_q + 1'b1;
        2'b01:   inflight_q <= inflight_q - 1'b1;
        default: ;  // none or both, count unchanged
      endcase
    end
  end

  // on flush every owed reply becomes stale
  // a reply landing in the flush cycle is already one of them
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      discard_q <= '0;
    else if (if_flush_i)
    begin
      if (rsp_hit && (inflight_q != '0))
        discard_q <= inflight_q - 1'b1;
      else
        discard_q <= inflight_q;
    end
    else if (rsp_hit && (discard_q != '0))
      discard_q <= discard_q - 1'b1;  // drop one stale reply
  end

  //////////////////////////////
  // to the cpu
  //////////////////////////////
  assign if_ack_o = cfg_i.fetch_en & biu_stb_ack_i & ~if_flush_i;  // cpu may advance pc

  assign rsp_show = ~(if_flush_i | flush_dly_q) & (discard_q == '0);

  always_comb
  begin
    // pc rebuilt from word address plus halfword offset
    parcel_o.pc    = {biu_rsp_i.addr[`FETCH_XLEN-1:`FETCH_TAG_W+1], biu_rsp_i.tag, 1'b0};
    parcel_o.data  = biu_rsp_i.data;
    parcel_o.valid = '0;
    if (rsp_show && biu_rsp_i.ack)
      parcel_o.valid = {`FETCH_NPARCEL{1'b1}} << biu_rsp_i.tag;  // skip leading halfwords
    parcel_o.err   = rsp_show & biu_rsp_i.err;
  end

  //////////////////////////////
  // to the bus interface unit
  //////////////////////////////
  assign biu_stb_o = cfg_i.fetch_en & ~if_flush_i & if_req_i;  // never strobe while flushing

  always_comb
  begin
    biu_req_o.addr = {if_nxt_pc_i[`FETCH_XLEN-1:`FETCH_TAG_W+1], {(`FETCH_TAG_W+1){1'b0}}};
    biu_req_o.tag  = (`FETCH_HAS_RVC != 0) ? if_nxt_pc_i[1 +: `FETCH_TAG_W] : '0;
    biu_req_o.prot = cfg_i.prot;
  end

endmodule

/* design/fetch_biu.sv */
/* queues up to FETCH_DEPTH reads and runs them one at a time on a four-phase port
   an entry leaves the queue when its memory ack is seen; replies stay in order */
`include "fetch_params.svh"

module fetch_biu (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // core side
  input  logic                     stb_i,
  output logic                     stb_ack_o,
  input  fetch_pkg::biu_req_t      req_i,
  output fetch_pkg::biu_rsp_t      rsp_o,
  // memory port
  output logic                     mem_req_o,
  output logic [`FETCH_XLEN-1:0]   mem_addr_o,
  output fetch_pkg::fetch_prot_t   mem_prot_o,
  input  logic                     mem_ack_i,
  input  logic [`FETCH_XLEN-1:0]   mem_rdata_i,
  input  logic                     mem_err_i
);

  localparam int unsigned PTR_W = $clog2(`FETCH_DEPTH);
  localparam int unsigned CNT_W = PTR_W + 1;
  localparam logic [CNT_W-1:0] DEPTH_C = CNT_W'(`FETCH_DEPTH);

  //////////////////////////////
  // signals
  //////////////////////////////
  fetch_pkg::biu_req_t       fifo_q [`FETCH_DEPTH];  // request storage
  fetch_pkg::biu_req_t       head;                   // oldest entry, drives the port
  logic [PTR_W-1:0]          wr_ptr_q;
  logic [PTR_W-1:0]          rd_ptr_q;
  logic [CNT_W-1:0]          count_q;
  logic                      full;
  logic                      push;
  logic                      pop;
  logic                      pending;  // work for the sequencer
  fetch_pkg::mem_state_e     state_q;
  fetch_pkg::mem_state_e     state_d;

  logic [`FETCH_XLEN-1:0]    rsp_data_q;
  logic [`FETCH_XLEN-1:0]    rsp_addr_q;
  logic [`FETCH_TAG_W-1:0]   rsp_tag_q;
  logic                      rsp_ack_q;
  logic                      rsp_err_q;

  //////////////////////////////
  // request queue
  //////////////////////////////
  assign full      = (count_q == DEPTH_C);
  assign stb_ack_o = ~full;               // same-cycle accept while there is room
  assign push      = stb_i & ~full;
  assign pop       = (state_q == fetch_pkg::MEM_REQ) & mem_ack_i;  // transfer done
  assign pending   = (count_q != '0) | push;
  assign head      = fifo_q[rd_ptr_q];

  always_ff @(posedge clk_i)
  begin
    if (push)
      fifo_q[wr_ptr_q] <= req_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= wr_ptr_q + 1'b1;  // power-of-two depth wraps by itself
      if (pop)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

  //////////////////////////////
  // memory sequencer
  //////////////////////////////
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      fetch_pkg::MEM_IDLE:
        if (pending)
          state_d = fetch_pkg::MEM_REQ;      // req rises next cycle
      fetch_pkg::MEM_REQ:
        if (mem_ack_i)
          state_d = fetch_pkg::MEM_RELEASE;  // data sampled, drop req
      fetch_pkg::MEM_RELEASE:
        if (!mem_ack_i)
          state_d = pending ? fetch_pkg::MEM_REQ : fetch_pkg::MEM_IDLE;
      default:
        state_d = fetch_pkg::MEM_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      state_q <= fetch_pkg::MEM_IDLE;
    else
      state_q <= state_d;
  end

  assign mem_req_o  = (state_q == fetch_pkg::MEM_REQ);
  assign mem_addr_o = head.addr;  // stable until the entry pops
  assign mem_prot_o = head.prot;

  //////////////////////////////
  // response register
  //////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      rsp_ack_q <= 1'b0;
      rsp_err_q <= 1'b0;
    end
    else
    begin
      rsp_ack_q <= pop & ~mem_err_i;  // single cycle pulse
      rsp_err_q <= pop & mem_err_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (pop)
    begin
      rsp_data_q <= mem_rdata_i;
      rsp_addr_q <= head.addr;
      rsp_tag_q  <= head.tag;
    end
  end

  assign rsp_o = '{data: rsp_data_q, addr: rsp_addr_q, tag: rsp_tag_q,
                   ack: rsp_ack_q, err: rsp_err_q};

endmodule

/* design/fetch_cfg_regs.sv */
/* host registers beside the fetch core, one access per four-phase handshake
   status counters saturate and ignore writes */
`include "fetch_params.svh"

module fetch_cfg_regs (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // host port
  input  logic                     cfg_req_i,
  input  fetch_pkg::cfg_op_e       cfg_op_i,
  input  fetch_pkg::cfg_reg_e      cfg_addr_i,
  input  logic [`FETCH_XLEN-1:0]   cfg_wdata_i,
  output logic                     cfg_ack_o,
  output logic [`FETCH_XLEN-1:0]   cfg_rdata_o,
  // fetch core
  input  fetch_pkg::parcel_t       parcel_i,
  output fetch_pkg::fetch_cfg_t    cfg_o
);

  //////////////////////////////
  // signals
  //////////////////////////////
  logic                      fetch_en_q;
  fetch_pkg::fetch_prot_t    prot_q;
  logic [`FETCH_CNT_W-1:0]   parcel_cnt_q;
  logic [`FETCH_CNT_W-1:0]   error_cnt_q;
  logic                      ack_q;
  logic                      hs_start;   // new request seen, ack still low
  logic [`FETCH_XLEN-1:0]    rdata_d;
  logic [`FETCH_XLEN-1:0]    rdata_q;

  assign hs_start = cfg_req_i & ~ack_q;

  //////////////////////////////
  // four-phase responder
  //////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      ack_q <= 1'b0;
    else if (hs_start)
      ack_q <= 1'b1;   // one cycle after req
    else if (!cfg_req_i)
      ack_q <= 1'b0;   // release once host drops req
  end

  always_comb
  begin
    rdata_d = '0;
    case (cfg_addr_i)
      fetch_pkg::REG_CTRL:    rdata_d[0]   = fetch_en_q;
      fetch_pkg::REG_PROT:    rdata_d[2:0] = prot_q;
      fetch_pkg::REG_PARCELS: rdata_d      = `FETCH_XLEN'(parcel_cnt_q);
      fetch_pkg::REG_ERRORS:  rdata_d      = `FETCH_XLEN'(error_cnt_q);
      default:                rdata_d      = '0;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (hs_start)
      rdata_q <= rdata_d;  // held for the whole ack phase
  end

  assign cfg_ack_o   = ack_q;
  assign cfg_rdata_o = rdata_q;

  //////////////////////////////
  // control registers
  //////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      fetch_en_q <= 1'b0;  // fetch held off until the host enables it
      prot_q     <= '{instr: 1'b1, priv: 1'b0, cacheable: 1'b0};
    end
    else if (hs_start && (cfg_op_i == fetch_pkg::CFG_WRITE))
    begin
      case (cfg_addr_i)
        fetch_pkg::REG_CTRL: fetch_en_q <= cfg_wdata_i[0];
        fetch_pkg::REG_PROT: prot_q     <= fetch_pkg::fetch_prot_t'(cfg_wdata_i[2:0]);
        default:             ;  // status registers are read only
      endcase
    end
  end

  assign cfg_o = '{fetch_en: fetch_en_q, prot: prot_q};

  //////////////////////////////
  // status counters
  //////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      parcel_cnt_q <= '0;
      error_cnt_q  <= '0;
    end
    else
    begin
      if ((|parcel_i.valid) && (parcel_cnt_q != '1))
        parcel_cnt_q <= parcel_cnt_q + 1'b1;  // one per delivered word
      if (parcel_i.err && (error_cnt_q != '1))
        error_cnt_q <= error_cnt_q + 1'b1;
    end
  end

endmodule

/* design/fetch_top.sv */
/* uncached instruction fetch path: core, bus interface unit and config block
   fetch stays off after reset until the host sets REG_CTRL bit 0 */
`include "fetch_params.svh"

module fetch_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // cpu side
  input  logic [`FETCH_XLEN-1:0]   if_nxt_pc_i,
  input  logic                     if_req_i,
  output logic                     if_ack_o,
  input  logic                     if_flush_i,
  output fetch_pkg::parcel_t       if_parcel_o,
  // memory port
  output logic                     mem_req_o,
  output logic [`FETCH_XLEN-1:0]   mem_addr_o,
  output fetch_pkg::fetch_prot_t   mem_prot_o,
  input  logic                     mem_ack_i,
  input  logic [`FETCH_XLEN-1:0]   mem_rdata_i,
  input  logic                     mem_err_i,
  // host port
  input  logic                     cfg_req_i,
  input  fetch_pkg::cfg_op_e       cfg_op_i,
  input  fetch_pkg::cfg_reg_e      cfg_addr_i,
  input  logic [`FETCH_XLEN-1:0]   cfg_wdata_i,
  output logic                     cfg_ack_o,
  output logic [`FETCH_XLEN-1:0]   cfg_rdata_o
);

  //////////////////////////////
  // internal wiring
  //////////////////////////////
  logic                    biu_stb;      // core strobe
  logic                    biu_stb_ack;  // queue has room
  fetch_pkg::biu_req_t     biu_req;
  fetch_pkg::biu_rsp_t     biu_rsp;
  fetch_pkg::fetch_cfg_t   fetch_cfg;    // enable and prot to the core

  fetch_nocache_core u_core (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .if_nxt_pc_i   (if_nxt_pc_i),
    .if_req_i      (if_req_i),
    .if_ack_o      (if_ack_o),
    .if_flush_i    (if_flush_i),
    .parcel_o      (if_parcel_o),
    .cfg_i         (fetch_cfg),
    .biu_stb_o     (biu_stb),
    .biu_stb_ack_i (biu_stb_ack),
    .biu_req_o     (biu_req),
    .biu_rsp_i     (biu_rsp)
  );

  fetch_biu u_biu (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .stb_i       (biu_stb),
    .stb_ack_o   (biu_stb_ack),
    .req_i       (biu_req),
    .rsp_o       (biu_rsp),
    .mem_req_o   (mem_req_o),
    .mem_addr_o  (mem_addr_o),
    .mem_prot_o  (mem_prot_o),
    .mem_ack_i   (mem_ack_i),
    .mem_rdata_i (mem_rdata_i),
    .mem_err_i   (mem_err_i)
  );

  // counters watch the same parcels the cpu receives
  fetch_cfg_regs u_cfg (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cfg_req_i   (cfg_req_i),
    .cfg_op_i    (cfg_op_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_ack_o   (cfg_ack_o),
    .cfg_rdata_o (cfg_rdata_o),
    .parcel_i    (if_parcel_o),
    .cfg_o       (fetch_cfg)
  );

endmodule

/* bench/fetch_clkgen.sv */
/* bench clock with period 10, first rising edge at 5
   reset is low from time 0 for 16 rising edges, released on a falling edge */
module fetch_clkgen (
  output logic clk_o,
  output logic rst_no
);

  always
  begin
    clk_o = 1'b0;
    #5;
    clk_o = 1'b1;
    #5;
  end

  initial
  begin
    rst_no = 1'b0;
    repeat (16) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;  // away from the active edge
  end

endmodule

/* bench/fetch_mem_model.sv */
/* four-phase read responder, outputs change on the falling edge only
   data is word address xor 5a5a0000, addresses from f000 up answer with err */
module fetch_mem_model (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        mem_req_i,
  input  logic [31:0] mem_addr_i,
  output logic        mem_ack_o,
  output logic [31:0] mem_rdata_o,
  output logic        mem_err_o
);

  localparam logic [31:0] DATA_KEY = 32'h5a5a0000;
  localparam logic [31:0] ERR_BASE = 32'h0000f000;  // error window start

  logic        ack_q   = 1'b0;
  logic [31:0] rdata_q = '0;
  logic        err_q   = 1'b0;
  logic        busy_q  = 1'b0;          // req seen, latency running
  logic [2:0]  wait_q  = '0;            // cycles left before ack
  logic [31:0] lcg_q   = 32'hdc77d31b;  // latency generator state

  // numerical recipes constants
  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  //////////////////////////////
  // responder
  //////////////////////////////
  always @(negedge clk_i)
  begin
    if (!rst_ni)
    begin
      ack_q  <= 1'b0;
      err_q  <= 1'b0;
      busy_q <= 1'b0;
      wait_q <= '0;
    end
    else if (ack_q)
    begin
      if (!mem_req_i)
      begin
        ack_q <= 1'b0;  // req gone, close the handshake
        err_q <= 1'b0;
      end
    end
    else if (mem_req_i)
    begin
      if (!busy_q)
      begin
        busy_q <= 1'b1;
        lcg_q  <= lcg_next(lcg_q);
        wait_q <= 3'(lcg_q[31:16] % 16'd6);  // 1 to 6 cycles to ack
      end
      else if (wait_q != '0)
        wait_q <= wait_q - 3'd1;
      else
      begin
        busy_q  <= 1'b0;
        ack_q   <= 1'b1;
        rdata_q <= mem_addr_i ^ DATA_KEY;
        err_q   <= (mem_addr_i >= ERR_BASE);
      end
    end
  end

  assign mem_ack_o   = ack_q;
  assign mem_rdata_o = rdata_q;
  assign mem_err_o   = err_q;

endmodule

/* bench/fetch_tb.sv */
/* directed tests of the fetch path with inputs changed on the falling edge
   outputs are sampled on the rising edge and the first failed check ends the run */
`include "fetch_params.svh"

module fetch_tb;

  localparam logic [31:0] DATA_KEY       = 32'h5a5a0000;
  localparam logic [31:0] ERR_BASE       = 32'h0000f000;
  localparam int unsigned TIMEOUT_CYCLES = 4000;  // all tests with margin
  localparam fetch_pkg::fetch_prot_t TEST_PROT = '{instr: 1'b1, priv: 1'b1, cacheable: 1'b0};

  logic                   clk;
  logic                   rst_n;
  logic [`FETCH_XLEN-1:0] if_nxt_pc;
  logic                   if_req;
  logic                   if_ack;
  logic                   if_flush;
  fetch_pkg::parcel_t     if_parcel;
  logic                   mem_req;
  logic [`FETCH_XLEN-1:0] mem_addr;
  fetch_pkg::fetch_prot_t mem_prot;
  logic                   mem_ack;
  logic [`FETCH_XLEN-1:0] mem_rdata;
  logic                   mem_err;
  logic                   cfg_req;
  fetch_pkg::cfg_op_e     cfg_op;
  fetch_pkg::cfg_reg_e    cfg_addr;
  logic [`FETCH_XLEN-1:0] cfg_wdata;
  logic                   cfg_ack;
  logic [`FETCH_XLEN-1:0] cfg_rdata;

  logic [31:0]            exp_pc_q [$];          // scoreboard of fetches in request order
  logic [31:0]            exp_addr_q [$];        // word addresses of all accepted fetches
  logic [31:0]            mon_pc;
  logic                   mem_req_prev = 1'b0;   // mem_req at the previous edge
  logic [31:0]            n_valid   = '0;        // parcels with data seen
  logic [31:0]            n_err     = '0;        // error parcels seen
  logic [31:0]            cycle_cnt = '0;
  fetch_pkg::fetch_prot_t exp_prot  = '{instr: 1'b1, priv: 1'b0, cacheable: 1'b0};

  fetch_clkgen u_clkgen (.clk_o(clk), .rst_no(rst_n));

  fetch_mem_model u_mem (
    .clk_i (clk), .rst_ni (rst_n), .mem_req_i (mem_req), .mem_addr_i (mem_addr),
    .mem_ack_o (mem_ack), .mem_rdata_o (mem_rdata), .mem_err_o (mem_err)
  );

  fetch_top uut (
    .clk_i (clk), .rst_ni (rst_n),
    .if_nxt_pc_i (if_nxt_pc), .if_req_i (if_req), .if_ack_o (if_ack),
    .if_flush_i (if_flush), .if_parcel_o (if_parcel),
    .mem_req_o (mem_req), .mem_addr_o (mem_addr), .mem_prot_o (mem_prot),
    .mem_ack_i (mem_ack), .mem_rdata_i (mem_rdata), .mem_err_i (mem_err),
    .cfg_req_i (cfg_req), .cfg_op_i (cfg_op), .cfg_addr_i (cfg_addr),
    .cfg_wdata_i (cfg_wdata), .cfg_ack_o (cfg_ack), .cfg_rdata_o (cfg_rdata)
  );

  //////////////////////////////
  // reference rules
  //////////////////////////////
  function automatic logic [31:0] word_addr(input logic [31:0] pc);
    return {pc[31:2], 2'b00};
  endfunction

  function automatic logic exp_err(input logic [31:0] pc);
    return (word_addr(pc) >= ERR_BASE);
  endfunction

  function automatic logic [31:0] exp_data(input logic [31:0] pc);
    return word_addr(pc) ^ DATA_KEY;
  endfunction

  function automatic logic [1:0] exp_valid(input logic [31:0] pc);
    if (exp_err(pc))
      return 2'b00;
    if ((`FETCH_HAS_RVC != 0) && pc[1])
      return 2'b10;  // lower halfword skipped
    return 2'b11;
  endfunction

  //////////////////////////////
  // checking helpers
  //////////////////////////////
  task automatic stop_with_failure();
    $display("Test failed");
    $fatal(1, "stopped at cycle %0d", cycle_cnt);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    assert (got === expected)
    else
    begin
      $display("MISMATCH %s: got %h expected %h", name, got, expected);
      stop_with_failure();
    end
  endtask

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 32'd1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("timeout: no finish within %0d cycles", TIMEOUT_CYCLES);
      stop_with_failure();
    end
  end

  // every transfer carries the programmed prot and reads the oldest accepted word
  always @(posedge clk)
  begin
    mem_req_prev <= mem_req;
    if (rst_n && mem_req)
      check_value("mem_prot_o", 32'(mem_prot), 32'(exp_prot));
    if (rst_n && mem_req && !mem_req_prev)
    begin
      assert (exp_addr_q.size() != 0)
      else
      begin
        $display("memory transfer at %h started with no fetch accepted", mem_addr);
        stop_with_failure();
      end
      check_value("mem_addr_o", mem_addr, exp_addr_q.pop_front());
    end
  end

  // parcel scoreboard
  always @(posedge clk)
  begin
    if (rst_n && ((|if_parcel.valid) || if_parcel.err))
    begin
      assert (exp_pc_q.size() != 0)
      else
      begin
        $display("parcel for pc %h arrived with no fetch owed", if_parcel.pc);
        stop_with_failure();
      end
      mon_pc = exp_pc_q.pop_front();
      check_value("parcel.pc", if_parcel.pc, mon_pc);
      check_value("parcel.err", 32'(if_parcel.err), 32'(exp_err(mon_pc)));
      check_value("parcel.valid", 32'(if_parcel.valid), 32'(exp_valid(mon_pc)));
      if (exp_err(mon_pc))
        n_err = n_err + 32'd1;
      else
      begin
        check_value("parcel.data", if_parcel.data, exp_data(mon_pc));
        n_valid = n_valid + 32'd1;
      end
    end
  end

  //////////////////////////////
  // bus drivers
  //////////////////////////////
  task automatic cfg_access(input fetch_pkg::cfg_op_e op, input fetch_pkg::cfg_reg_e addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int unsigned waited;
    waited = 0;
    @(negedge clk);
    cfg_op    = op;
    cfg_addr  = addr;
    cfg_wdata = wdata;
    cfg_req   = 1'b1;
    @(posedge clk);
    while (!cfg_ack)
    begin
      @(posedge clk);
      waited++;
    end
    assert (waited == 1)
    else
    begin
      $display("cfg_ack_o rose %0d cycles after cfg_req_i instead of 1", waited);
      stop_with_failure();
    end
    rdata = cfg_rdata;
    @(negedge clk);
    cfg_req = 1'b0;
    @(posedge clk);
    while (cfg_ack)
      @(posedge clk);
  endtask

  task automatic cfg_write(input fetch_pkg::cfg_reg_e addr, input logic [31:0] wdata);
    logic [31:0] unused_rd;
    cfg_access(fetch_pkg::CFG_WRITE, addr, wdata, unused_rd);
  endtask

  // holds the request until the core acks it and logs it when tracked
  task automatic issue_fetch(input logic [31:0] pc, input bit track);
    @(negedge clk);
    if_nxt_pc = pc;
    if_req    = 1'b1;
    @(posedge clk);
    while (!if_ack)
      @(posedge clk);
    exp_addr_q.push_back(word_addr(pc));  // memory read happens even when flushed
    if (track)
      exp_pc_q.push_back(pc);
  endtask

  task automatic release_req();
    @(negedge clk);
    if_req = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_pc_q.size() != 0)
      @(posedge clk);
    repeat (4) @(posedge clk);  // a stray reply would show up here
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////
  task automatic check_reset_state();
    logic [31:0] rd;
    @(posedge clk);
    check_value("mem_req_o", 32'(mem_req), 32'h0);
    check_value("if_ack_o", 32'(if_ack), 32'h0);
    check_value("cfg_ack_o", 32'(cfg_ack), 32'h0);
    check_value("parcel.valid", 32'(if_parcel.valid), 32'h0);
    cfg_access(fetch_pkg::CFG_READ, fetch_pkg::REG_CTRL, '0, rd);
    check_value("REG_CTRL", rd, 32'h0);
  endtask

  task automatic test_config();
    logic [31:0] rd;
    @(negedge clk);
    if_nxt_pc = 32'h0000_0800;
    if_req    = 1'b1;
    repeat (20)
    begin
      @(posedge clk);
      check_value("if_ack_o", 32'(if_ack), 32'h0);  // fetch still disabled
    end
    release_req();
    exp_prot = TEST_PROT;
    cfg_write(fetch_pkg::REG_PROT, 32'(TEST_PROT));
    cfg_write(fetch_pkg::REG_CTRL, 32'h1);
    cfg_access(fetch_pkg::CFG_READ, fetch_pkg::REG_PROT, '0, rd);
    check_value("REG_PROT", rd, 32'(TEST_PROT));
    cfg_access(fetch_pkg::CFG_READ, fetch_pkg::REG_CTRL, '0, rd);
    check_value("REG_CTRL", rd, 32'h1);
  endtask

  task automatic test_sequential();
    for (int i = 0; i < 8; i++)
      issue_fetch(32'h0000_1000 + 32'(4 * i), 1'b1);  // back to back
    release_req();
    wait_drain();
  endtask

  task automatic test_halfword();
    issue_fetch(32'h0000_1102, 1'b1);
    release_req();
    wait_drain();
  endtask

  // two owed replies are flushed and only the new pc may come back
  task automatic test_flush();
    issue_fetch(32'h0000_2000, 1'b0);
    issue_fetch(32'h0000_2004, 1'b0);
    @(negedge clk);
    if_req   = 1'b0;
    if_flush = 1'b1;
    @(posedge clk);
    check_value("if_ack_o", 32'(if_ack), 32'h0);
    @(negedge clk);
    if_flush = 1'b0;
    issue_fetch(32'h0000_2100, 1'b1);
    release_req();
    wait_drain();
  endtask

  task automatic test_bus_error();
    issue_fetch(32'h0000_f010, 1'b1);
    issue_fetch(32'h0000_3000, 1'b1);  // path recovers after the error
    release_req();
    wait_drain();
  endtask

  task automatic test_counters();
    logic [31:0] rd;
    cfg_write(fetch_pkg::REG_PARCELS, 32'h0000_ffff);  // read only so the write must not stick
    cfg_access(fetch_pkg::CFG_READ, fetch_pkg::REG_PARCELS, '0, rd);
    check_value("REG_PARCELS", rd, n_valid);
    cfg_access(fetch_pkg::CFG_READ, fetch_pkg::REG_ERRORS, '0, rd);
    check_value("REG_ERRORS", rd, n_err);
  endtask

  //////////////////////////////
  // sequence
  //////////////////////////////
  initial
  begin
    if_nxt_pc = '0;
    if_req    = 1'b0;
    if_flush  = 1'b0;
    cfg_req   = 1'b0;
    cfg_op    = fetch_pkg::CFG_READ;
    cfg_addr  = fetch_pkg::REG_CTRL;
    cfg_wdata = '0;
    @(posedge rst_n);
    check_reset_state();
    test_config();
    test_sequential();
    test_halfword();
    test_flush();
    test_bus_error();
    test_counters();
    $display("Test completed successfully");
    $finish;
  end

endmodule

/* fetch_nocache.f */
+incdir+design
design/fetch_pkg.sv
design/fetch_nocache_core.sv
design/fetch_biu.sv
design/fetch_cfg_regs.sv
design/fetch_top.sv
bench/fetch_clkgen.sv
bench/fetch_mem_model.sv
bench/fetch_tb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = fetch_tb
FILELIST = fetch_nocache.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = Test completed successfully

.PHONY: sim clean

# the log decides pass or fail, the grep status is the make status
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
